// ==== source/battle_config.svh ====
// screen geometry, sheet sizes, hp-bar colours and latency of the battle overlay, included by rtl and tb
`ifndef BATTLE_CONFIG_SVH
`define BATTLE_CONFIG_SVH

// team sprite origin, back view
`define TEAM_X 250
`define TEAM_Y 290
// enemy sprite origin, front view
`define ENEMY_X 410
`define ENEMY_Y 160

// one creature cell on the sheet
`define SPRITE_W 56
`define SPRITE_H 56
// sheet is four cells wide
`define SHEET_W 224

// fill area of the hp bar, border sits one pixel outside it
`define HP_X 280
`define HP_Y 270
`define HP_W 50
`define HP_H 5

// move grid, move 0 text origin and spacing to the other three
`define MOVE_X 40
`define MOVE_Y 400
`define MOVE_DX 150
`define MOVE_DY 40
`define PTR_GAP 9
`define GLYPH_W 8
`define GLYPH_H 16

`define HP_GREEN 24'h41ff74
`define HP_ORANGE 24'hffae42
`define HP_RED 24'hff3300
`define HP_BORDER 24'h000000

// decode, execute, result
`define PIPE_DEPTH 3

`endif

// ==== source/battle_pkg.sv ====
// shared types of the battle overlay pipeline, imported by every stage and by the testbench
package battle_pkg;

   // plain vectors with a meaning
   typedef logic [9:0] coord_t;
   typedef logic [5:0] offset_t;
   typedef logic [18:0] sprite_addr_t;
   typedef logic [2:0] poke_id_t;
   typedef logic [6:0] hp_t;
   typedef logic [1:0] move_slot_t;
   typedef logic [23:0] rgb_t;
   typedef logic [2:0] glyph_col_t;
   typedef logic [3:0] glyph_row_t;

   // which layer owns the pixel
   typedef enum logic [2:0] {
      LAYER_NONE,
      LAYER_POINTER,
      LAYER_HPBAR,
      LAYER_TEAM,
      LAYER_ENEMY
   } layer_e;

   // decode stage register
   typedef struct packed {
      logic valid;
      logic sprite_hit;
      logic sprite_is_enemy;
      poke_id_t poke_id;
      offset_t sprite_dx;
      offset_t sprite_dy;
      logic hp_box_hit;
      offset_t hp_dx;
      offset_t hp_dy;
      hp_t cur_hp;
      hp_t max_hp;
      logic ptr_hit;
      glyph_col_t ptr_col;
      glyph_row_t ptr_row;
   } decode_t;

   // execute stage register
   typedef struct packed {
      logic valid;
      logic sprite_hit;
      logic sprite_is_enemy;
      sprite_addr_t sprite_addr;
      logic hp_hit;
      rgb_t hp_rgb;
      logic ptr_hit;
      glyph_col_t ptr_col;
      glyph_row_t ptr_row;
   } exec_t;

   // what leaves the renderer per pixel
   typedef struct packed {
      layer_e layer;
      sprite_addr_t sprite_addr;
      rgb_t rgb;
      glyph_col_t glyph_col;
      glyph_row_t glyph_row;
   } pixel_out_t;

endpackage

// ==== source/region_decode.sv ====
// decode stage of the battle overlay, registers region hits and local offsets of each pixel
`include "battle_config.svh"

module region_decode (
   input  logic                   clk,
   input  logic                   reset,
   input  battle_pkg::coord_t     draw_x,
   input  battle_pkg::coord_t     draw_y,
   input  logic                   pixel_valid,
   input  battle_pkg::poke_id_t   team_id,
   input  battle_pkg::poke_id_t   enemy_id,
   input  battle_pkg::hp_t        cur_hp,
   input  battle_pkg::hp_t        max_hp,
   input  battle_pkg::move_slot_t hovered_move,
   output battle_pkg::decode_t    dec
);
   import battle_pkg::*;

   logic team_hit;
   logic enemy_hit;
   logic hp_box_hit;
   logic ptr_hit;
   coord_t ptr_x;
   coord_t ptr_y;
   decode_t dec_d;

   // half-open span test, origin inclusive
   function automatic logic in_span(coord_t pos, int unsigned origin, int unsigned size);
      return (pos >= origin) && (pos < origin + size);
   endfunction

   // pointer sits left of the hovered move text
   // bit 0 picks the column, bit 1 the row
   assign ptr_x = coord_t'(`MOVE_X - `PTR_GAP + (hovered_move[0] ? `MOVE_DX : 0));
   assign ptr_y = coord_t'(`MOVE_Y + (hovered_move[1] ? `MOVE_DY : 0));

   // hits only count for a valid pixel
   assign team_hit = pixel_valid
                  && in_span(draw_x, `TEAM_X, `SPRITE_W)
                  && in_span(draw_y, `TEAM_Y, `SPRITE_H);
   assign enemy_hit = pixel_valid
                   && in_span(draw_x, `ENEMY_X, `SPRITE_W)
                   && in_span(draw_y, `ENEMY_Y, `SPRITE_H);
   // border box, one pixel around the fill area
   assign hp_box_hit = pixel_valid
                    && in_span(draw_x, `HP_X - 1, `HP_W + 2)
                    && in_span(draw_y, `HP_Y - 1, `HP_H + 2);
   assign ptr_hit = pixel_valid
                 && in_span(draw_x, ptr_x, `GLYPH_W)
                 && in_span(draw_y, ptr_y, `GLYPH_H);

   always_comb begin
      dec_d = '0;
      dec_d.valid = pixel_valid;
      dec_d.cur_hp = cur_hp;
      dec_d.max_hp = max_hp;
      // team checked first
      if (team_hit) begin
         dec_d.sprite_hit = 1'b1;
         dec_d.poke_id = team_id;
         dec_d.sprite_dx = offset_t'(draw_x - coord_t'(`TEAM_X));
         dec_d.sprite_dy = offset_t'(draw_y - coord_t'(`TEAM_Y));
      end else if (enemy_hit) begin
         dec_d.sprite_hit = 1'b1;
         dec_d.sprite_is_enemy = 1'b1;
         dec_d.poke_id = enemy_id;
         dec_d.sprite_dx = offset_t'(draw_x - coord_t'(`ENEMY_X));
         dec_d.sprite_dy = offset_t'(draw_y - coord_t'(`ENEMY_Y));
      end
      // offsets from the border corner
      dec_d.hp_box_hit = hp_box_hit;
      dec_d.hp_dx = offset_t'(draw_x - coord_t'(`HP_X - 1));
      dec_d.hp_dy = offset_t'(draw_y - coord_t'(`HP_Y - 1));
      dec_d.ptr_hit = ptr_hit;
      dec_d.ptr_col = glyph_col_t'(draw_x - ptr_x);
      dec_d.ptr_row = glyph_row_t'(draw_y - ptr_y);
   end

   // payload follows every clock, only valid and hit flags clear
   always_ff @(posedge clk) begin
      dec <= dec_d;
      if (reset) begin
         dec.valid <= 1'b0;
         dec.sprite_hit <= 1'b0;
         dec.hp_box_hit <= 1'b0;
         dec.ptr_hit <= 1'b0;
      end
   end

   // screen layout keeps the two creatures apart
   a_sprites_disjoint: assert property (@(posedge clk) disable iff (reset)
      !(team_hit && enemy_hit))
      else $error("team and enemy sprite boxes overlap");

endmodule

// ==== source/sprite_address.sv ====
// execute stage of the battle overlay, maps a sprite hit to its sprite-sheet address
`include "battle_config.svh"

module sprite_address (
   input  battle_pkg::decode_t      dec,
   output battle_pkg::sprite_addr_t sprite_addr
);
   import battle_pkg::*;

   logic [1:0] col_idx;
   sprite_addr_t col_base;
   sprite_addr_t row_base;
   sprite_addr_t line_base;
   sprite_addr_t pix_addr;

   // sheet layout, four cells per row
   // even ids back at column 0, odd ids back at column 2
   // front view sits one column right of the back view
   assign col_idx = {dec.poke_id[0], dec.sprite_is_enemy};

   // x start of the cell
   assign col_base = sprite_addr_t'(col_idx * `SPRITE_W);

   // two creatures per sheet row
   assign row_base = sprite_addr_t'(dec.poke_id[2:1] * (`SHEET_W * `SPRITE_H));

   // line inside the cell
   assign line_base = sprite_addr_t'(dec.sprite_dy * `SHEET_W);

   assign pix_addr = col_base + row_base + line_base + sprite_addr_t'(dec.sprite_dx);

   // zero outside both sprite boxes
   assign sprite_addr = dec.sprite_hit ? pix_addr : '0;

endmodule

// ==== source/hp_bar_shade.sv ====
// execute stage of the battle overlay, sizes the hp fill and shades border, fill and empty pixels
`include "battle_config.svh"

module hp_bar_shade (
   input  battle_pkg::decode_t dec,
   output logic                hp_hit,
   output battle_pkg::rgb_t    hp_rgb
);
   import battle_pkg::*;

   // HP_W * cur_hp peaks at 50 * 127
   logic [12:0] hp_scaled;
   offset_t fill_w;
   offset_t fill_col;
   logic on_border;
   logic in_fill;

   always_comb begin
      hp_scaled = 13'(`HP_W * dec.cur_hp);
      // full health draws the whole bar
      if (dec.cur_hp == dec.max_hp) begin
         fill_w = offset_t'(`HP_W);
      end else if (dec.max_hp == '0) begin
         // no max, nothing to scale against
         fill_w = '0;
      end else begin
         fill_w = offset_t'((hp_scaled / dec.max_hp) % `HP_W);
      end
      if (dec.valid) begin
         a_fill_in_bar: assert final (fill_w <= offset_t'(`HP_W))
            else $error("hp fill width %0d past bar width", fill_w);
      end
   end

   // outer ring of the border box
   assign on_border = (dec.hp_dx == '0)
                   || (dec.hp_dx == offset_t'(`HP_W + 1))
                   || (dec.hp_dy == '0)
                   || (dec.hp_dy == offset_t'(`HP_H + 1));

   // column inside the fill area
   assign fill_col = dec.hp_dx - offset_t'(1);
   assign in_fill = !on_border && (fill_col < fill_w);

   // empty interior stays transparent
   assign hp_hit = dec.hp_box_hit && (on_border || in_fill);

   always_comb begin
      if (!hp_hit) begin
         hp_rgb = '0;
      end else if (on_border) begin
         hp_rgb = `HP_BORDER;
      end else if (2 * fill_w > `HP_W) begin
         // above half
         hp_rgb = `HP_GREEN;
      end else if (5 * fill_w > `HP_W) begin
         // a fifth to a half
         hp_rgb = `HP_ORANGE;
      end else begin
         hp_rgb = `HP_RED;
      end
   end

endmodule

// ==== source/layer_result.sv ====
// result stage of the battle overlay, picks the top layer and registers the pixel outputs
module layer_result (
   input  logic                   clk,
   input  logic                   reset,
   input  battle_pkg::exec_t      ex,
   output logic                   out_valid,
   output battle_pkg::pixel_out_t pixel
);
   import battle_pkg::*;

   pixel_out_t pixel_d;

   // pointer over hp bar over sprites
   // fields of the losing layers stay zero
   always_comb begin
      pixel_d = '0;
      if (ex.ptr_hit) begin
         pixel_d.layer = LAYER_POINTER;
         pixel_d.glyph_col = ex.ptr_col;
         pixel_d.glyph_row = ex.ptr_row;
      end else if (ex.hp_hit) begin
         pixel_d.layer = LAYER_HPBAR;
         pixel_d.rgb = ex.hp_rgb;
      end else if (ex.sprite_hit) begin
         // same address path, layer tells the sheets apart
         pixel_d.layer = ex.sprite_is_enemy ? LAYER_ENEMY : LAYER_TEAM;
         pixel_d.sprite_addr = ex.sprite_addr;
      end
   end

   // whole pixel clears on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         pixel <= '0;
      end else begin
         out_valid <= ex.valid;
         pixel <= pixel_d;
      end
   end

   // hits are qualified at decode, two stages back
   a_idle_no_layer: assert property (@(posedge clk) disable iff (reset)
      !out_valid |-> pixel.layer == LAYER_NONE)
      else $error("layer %s without out_valid", pixel.layer.name());

endmodule

// ==== source/battle_overlay.sv ====
// top of the battle overlay renderer, three-stage pipeline from pixel coordinate to layer result
module battle_overlay (
   input  logic                   clk,
   input  logic                   reset,
   input  battle_pkg::coord_t     draw_x,
   input  battle_pkg::coord_t     draw_y,
   input  logic                   pixel_valid,
   input  battle_pkg::poke_id_t   team_id,
   input  battle_pkg::poke_id_t   enemy_id,
   input  battle_pkg::hp_t        cur_hp,
   input  battle_pkg::hp_t        max_hp,
   input  battle_pkg::move_slot_t hovered_move,
   output logic                   out_valid,
   output battle_pkg::pixel_out_t pixel
);
   import battle_pkg::*;

   decode_t dec;
   exec_t ex;
   sprite_addr_t sprite_addr;
   logic hp_hit;
   rgb_t hp_rgb;

   // stage 1, region hits and offsets
   region_decode i_decode (
      .clk          (clk),
      .reset        (reset),
      .draw_x       (draw_x),
      .draw_y       (draw_y),
      .pixel_valid  (pixel_valid),
      .team_id      (team_id),
      .enemy_id     (enemy_id),
      .cur_hp       (cur_hp),
      .max_hp       (max_hp),
      .hovered_move (hovered_move),
      .dec          (dec)
   );

   // stage 2, both execute units run off the decode register
   sprite_address i_sprite (
      .dec         (dec),
      .sprite_addr (sprite_addr)
   );

   hp_bar_shade i_hp (
      .dec    (dec),
      .hp_hit (hp_hit),
      .hp_rgb (hp_rgb)
   );

   // execute register, pointer fields pass straight through
   always_ff @(posedge clk) begin
      if (reset) begin
         ex <= '0;
      end else begin
         ex.valid <= dec.valid;
         ex.sprite_hit <= dec.sprite_hit;
         ex.sprite_is_enemy <= dec.sprite_is_enemy;
         ex.sprite_addr <= sprite_addr;
         ex.hp_hit <= hp_hit;
         ex.hp_rgb <= hp_rgb;
         ex.ptr_hit <= dec.ptr_hit;
         ex.ptr_col <= dec.ptr_col;
         ex.ptr_row <= dec.ptr_row;
      end
   end

   // stage 3, layer priority
   layer_result i_result (
      .clk       (clk),
      .reset     (reset),
      .ex        (ex),
      .out_valid (out_valid),
      .pixel     (pixel)
   );

endmodule

// ==== verif/battle_ref_pkg.sv ====
// testbench reference model of the battle overlay, gives the expected pixel result for one pixel
`include "battle_config.svh"

package battle_ref_pkg;
   import battle_pkg::*;

   // layer priority: pointer, then hp bar, then the team or enemy sprite
   function automatic pixel_out_t expected_pixel(coord_t x, coord_t y, poke_id_t team_id,
                                                 poke_id_t enemy_id, hp_t cur_hp, hp_t max_hp,
                                                 move_slot_t hovered_move);
      pixel_out_t p;
      int px;
      int py;
      int ptr_x;
      int ptr_y;
      int hx;
      int hy;
      int fill;
      int id;
      int enemy;
      int dx;
      int dy;
      p = '0;
      px = x;
      py = y;
      // pointer cell left of the hovered move text
      ptr_x = `MOVE_X - `PTR_GAP + (hovered_move[0] ? `MOVE_DX : 0);
      ptr_y = `MOVE_Y + (hovered_move[1] ? `MOVE_DY : 0);
      if (px >= ptr_x && px < ptr_x + `GLYPH_W && py >= ptr_y && py < ptr_y + `GLYPH_H) begin
         p.layer = LAYER_POINTER;
         p.glyph_col = glyph_col_t'(px - ptr_x);
         p.glyph_row = glyph_row_t'(py - ptr_y);
         return p;
      end
      // hp box measured from the border corner
      hx = px - (`HP_X - 1);
      hy = py - (`HP_Y - 1);
      if (hx >= 0 && hx < `HP_W + 2 && hy >= 0 && hy < `HP_H + 2) begin
         if (cur_hp == max_hp) fill = `HP_W;
         else if (max_hp == 0) fill = 0;
         else fill = ((`HP_W * int'(cur_hp)) / int'(max_hp)) % `HP_W;
         if (hx == 0 || hx == `HP_W + 1 || hy == 0 || hy == `HP_H + 1) begin
            p.layer = LAYER_HPBAR;
            p.rgb = `HP_BORDER;
            return p;
         end
         if (hx - 1 < fill) begin
            p.layer = LAYER_HPBAR;
            p.rgb = (2 * fill > `HP_W) ? `HP_GREEN : (5 * fill > `HP_W) ? `HP_ORANGE : `HP_RED;
            return p;
         end
         // empty interior shows what lies below
      end
      // team before enemy
      if (px >= `TEAM_X && px < `TEAM_X + `SPRITE_W && py >= `TEAM_Y && py < `TEAM_Y + `SPRITE_H) begin
         id = team_id;
         enemy = 0;
         dx = px - `TEAM_X;
         dy = py - `TEAM_Y;
      end else if (px >= `ENEMY_X && px < `ENEMY_X + `SPRITE_W
                   && py >= `ENEMY_Y && py < `ENEMY_Y + `SPRITE_H) begin
         id = enemy_id;
         enemy = 1;
         dx = px - `ENEMY_X;
         dy = py - `ENEMY_Y;
      end else begin
         return p;
      end
      p.layer = enemy ? LAYER_ENEMY : LAYER_TEAM;
      // column pair per id parity, sheet row per id pair
      p.sprite_addr = sprite_addr_t'(((id % 2) * 2 + enemy) * `SPRITE_W
                                     + (id / 2) * `SHEET_W * `SPRITE_H + dx + `SHEET_W * dy);
      return p;
   endfunction

endpackage

// ==== verif/battle_overlay_tb.sv ====
// self-checking testbench top that sweeps every overlay region and streams random pixels
`include "battle_config.svh"

module battle_overlay_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import battle_pkg::*;
   import battle_ref_pkg::*;

   // sprite sweeps, hp sweeps, pointer sweeps, background, streaming
   localparam int STIM_CYCLES = 16 * (`SPRITE_W + 2) * (`SPRITE_H + 2)
                              + 7 * (`HP_W + 4) * (`HP_H + 4)
                              + 16 * (`GLYPH_W + 2) * (`GLYPH_H + 2) + 64 + 2000;
   localparam int CYCLE_LIMIT = STIM_CYCLES + 1000;

   logic clk;
   logic reset;
   coord_t draw_x;
   coord_t draw_y;
   logic pixel_valid;
   poke_id_t team_id;
   poke_id_t enemy_id;
   hp_t cur_hp;
   hp_t max_hp;
   move_slot_t hovered_move;
   logic out_valid;
   pixel_out_t pixel;

   pixel_out_t expected_q[$];
   pixel_out_t exp_pix;
   int hp_levels[7] = '{100, 60, 50, 30, 20, 10, 0};
   int errors;
   int checks;
   int test_start;
   int cycle_cnt;
   int post_reset;

   battle_overlay i_dut (.*);

   always #5 clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Finished with errors");
         $finish;
      end
   end

   // compare at the falling edge where outputs are stable
   always @(negedge clk) begin
      if (reset || post_reset < `PIPE_DEPTH) begin
         if (out_valid !== 1'b0) begin
            $display("out_valid high during reset or within 3 cycles after it");
            errors++;
         end
         post_reset = reset ? 0 : post_reset + 1;
      end else if (out_valid) begin
         if (expected_q.size() == 0) begin
            $display("out_valid high with no pixel left in the expected queue");
            errors++;
         end else begin
            exp_pix = expected_q.pop_front();
            checks++;
            if (pixel.layer !== exp_pix.layer) begin
               $display("[FAIL] pixel.layer expected %h got %h", exp_pix.layer, pixel.layer);
               errors++;
            end
            if (pixel.sprite_addr !== exp_pix.sprite_addr) begin
               $display("[FAIL] pixel.sprite_addr expected %h got %h",
                        exp_pix.sprite_addr, pixel.sprite_addr);
               errors++;
            end
            if (pixel.rgb !== exp_pix.rgb) begin
               $display("[FAIL] pixel.rgb expected %h got %h", exp_pix.rgb, pixel.rgb);
               errors++;
            end
            if (pixel.glyph_col !== exp_pix.glyph_col) begin
               $display("[FAIL] pixel.glyph_col expected %h got %h",
                        exp_pix.glyph_col, pixel.glyph_col);
               errors++;
            end
            if (pixel.glyph_row !== exp_pix.glyph_row) begin
               $display("[FAIL] pixel.glyph_row expected %h got %h",
                        exp_pix.glyph_row, pixel.glyph_row);
               errors++;
            end
         end
      end
   end

   // one pixel and its state per clock
   // expected result queued for valid pixels only
   task automatic step(input int x, input int y, input logic valid, input poke_id_t t,
                       input poke_id_t e, input hp_t c, input hp_t m, input move_slot_t h);
      @(posedge clk);
      #1;
      draw_x = coord_t'(x);
      draw_y = coord_t'(y);
      pixel_valid = valid;
      team_id = t;
      enemy_id = e;
      cur_hp = c;
      max_hp = m;
      hovered_move = h;
      if (valid) begin
         expected_q.push_back(expected_pixel(coord_t'(x), coord_t'(y), t, e, c, m, h));
      end
   endtask

   // idle the input and wait for the pipeline to empty
   task automatic finish_test(input string name);
      @(posedge clk);
      #1;
      pixel_valid = 1'b0;
      while (expected_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);
      $display("test %s done, %0d errors", name, errors - test_start);
      test_start = errors;
   endtask

   initial begin
      int bx;
      int by;
      void'($urandom(32'h9fa8));
      clk = 1'b0;
      reset = 1'b1;
      // valid sprite pixel held through reset
      draw_x = coord_t'(`TEAM_X);
      draw_y = coord_t'(`TEAM_Y);
      pixel_valid = 1'b1;
      team_id = '0;
      enemy_id = '0;
      cur_hp = '0;
      max_hp = '0;
      hovered_move = '0;
      errors = 0;
      checks = 0;
      test_start = 0;
      cycle_cnt = 0;
      post_reset = 0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      pixel_valid = 1'b0;
      repeat (`PIPE_DEPTH) @(posedge clk);

      // both sprite boxes plus a one-pixel ring for every id
      for (int id = 0; id < 8; id++) begin
         for (int y = `TEAM_Y - 1; y <= `TEAM_Y + `SPRITE_H; y++) begin
            for (int x = `TEAM_X - 1; x <= `TEAM_X + `SPRITE_W; x++) begin
               step(x, y, 1'b1, poke_id_t'(id), poke_id_t'(7 - id), 7'd80, 7'd100, 2'd0);
            end
         end
         for (int y = `ENEMY_Y - 1; y <= `ENEMY_Y + `SPRITE_H; y++) begin
            for (int x = `ENEMY_X - 1; x <= `ENEMY_X + `SPRITE_W; x++) begin
               step(x, y, 1'b1, poke_id_t'(7 - id), poke_id_t'(id), 7'd80, 7'd100, 2'd0);
            end
         end
      end
      finish_test("sprites");

      // colour thresholds with the full bar included
      foreach (hp_levels[i]) begin
         for (int y = `HP_Y - 2; y <= `HP_Y + `HP_H + 1; y++) begin
            for (int x = `HP_X - 2; x <= `HP_X + `HP_W + 1; x++) begin
               step(x, y, 1'b1, 3'd0, 3'd1, hp_t'(hp_levels[i]), 7'd100, 2'd0);
            end
         end
      end
      finish_test("hp_bar");

      // all four pointer cells for each hovered move
      for (int h = 0; h < 4; h++) begin
         for (int s = 0; s < 4; s++) begin
            bx = `MOVE_X - `PTR_GAP + (s % 2) * `MOVE_DX;
            by = `MOVE_Y + (s / 2) * `MOVE_DY;
            for (int y = by - 1; y <= by + `GLYPH_H; y++) begin
               for (int x = bx - 1; x <= bx + `GLYPH_W; x++) begin
                  step(x, y, 1'b1, 3'd2, 3'd5, 7'd40, 7'd90, move_slot_t'(h));
               end
            end
         end
      end
      finish_test("pointer");

      // corners and the empty top-left of the screen
      step(0, 0, 1'b1, 3'd3, 3'd4, 7'd50, 7'd100, 2'd3);
      step(1023, 1023, 1'b1, 3'd3, 3'd4, 7'd50, 7'd100, 2'd3);
      step(639, 479, 1'b1, 3'd3, 3'd4, 7'd50, 7'd100, 2'd3);
      step(`TEAM_X - 1, `TEAM_Y + `SPRITE_H, 1'b1, 3'd3, 3'd4, 7'd50, 7'd100, 2'd3);
      repeat (60) begin
         step($urandom_range(0, 239), $urandom_range(0, 159), 1'($urandom_range(0, 1)),
              3'd6, 3'd1, 7'd5, 7'd100, 2'd1);
      end
      finish_test("background");

      // random state every clock with pixels aimed near a region most of the time
      repeat (2000) begin
         case ($urandom_range(0, 4))
            0: begin
               bx = `TEAM_X;
               by = `TEAM_Y;
            end
            1: begin
               bx = `ENEMY_X;
               by = `ENEMY_Y;
            end
            2: begin
               bx = `HP_X;
               by = `HP_Y;
            end
            3: begin
               bx = `MOVE_X - `PTR_GAP + $urandom_range(0, 1) * `MOVE_DX;
               by = `MOVE_Y + $urandom_range(0, 1) * `MOVE_DY;
            end
            default: begin
               bx = $urandom_range(4, 960);
               by = $urandom_range(4, 960);
            end
         endcase
         step(bx - 4 + $urandom_range(0, 63), by - 4 + $urandom_range(0, 63),
              1'($urandom_range(0, 1)), poke_id_t'($urandom_range(0, 7)),
              poke_id_t'($urandom_range(0, 7)), hp_t'($urandom_range(0, 127)),
              hp_t'($urandom_range(1, 127)), move_slot_t'($urandom_range(0, 3)));
      end
      finish_test("streaming");

      $display("tests 5, pixels compared %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+source
source/battle_pkg.sv
source/region_decode.sv
source/sprite_address.sv
source/hp_bar_shade.sv
source/layer_result.sv
source/battle_overlay.sv
verif/battle_ref_pkg.sv
verif/battle_overlay_tb.sv

// ==== Bender.yml ====
package:
  name: battle_overlay

sources:
  - include_dirs:
      - source
    files:
      - source/battle_pkg.sv
      - source/region_decode.sv
      - source/sprite_address.sv
      - source/hp_bar_shade.sv
      - source/layer_result.sv
      - source/battle_overlay.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/battle_ref_pkg.sv
      - verif/battle_overlay_tb.sv
